// ==== go_board.f ====
design/go_pkg.sv
design/pruner.sv
design/board_updater.sv
design/game_keeper.sv
design/go_board_top.sv
tb/go_ref_model.sv
tb/go_board_tb.sv

// ==== Makefile ====
VERILATOR  := verilator
TOP        := go_board_tb
LINT_TOP   := go_board_top
FILELIST   := go_board.f
OBJ_DIR    := obj_dir
FLAGS      := --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
LINT_FLAGS := --lint-only -Wall --timing --timescale 1ns/1ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== tb/go_board_tb.sv ====
module go_board_tb
    import go_ref_model::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int STROBE_TARGET = 400;
    localparam int MOVE_CYCLES   = 2 * (CELLS + 2) + 12;
    localparam int WATCHDOG_NS   = STROBE_TARGET * MOVE_CYCLES * 8;

    logic       clk_in;
    logic       rst_in;
    logic       move_strobe;
    logic [7:0] move_in;
    logic [1:0] board_out [REF_DIM-1:0][REF_DIM-1:0];
    logic       turn;
    logic       busy;
    logic       move_done;
    logic       move_rejected;
    logic [7:0] black_captures;
    logic [7:0] white_captures;

    int done_seen;
    int rejected_seen;
    int strobes;
    int single_caps;
    int multi_caps;

    go_board_top #(
        .BOARD_DIM     (REF_DIM)
    ) DUT (
        .clk_in        (clk_in),
        .rst_in        (rst_in),
        .move_strobe   (move_strobe),
        .move_in       (move_in),
        .board_out     (board_out),
        .turn          (turn),
        .busy          (busy),
        .move_done     (move_done),
        .move_rejected (move_rejected),
        .black_captures(black_captures),
        .white_captures(white_captures)
    );

    initial
    begin
        clk_in = 1'b0;
        forever #4 clk_in = ~clk_in;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired before all moves were played");
        $display("TEST FAIL");
        $fatal(1);
    end

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    task automatic expect_equal(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        assert (actual === expected)
        else
        begin
            $display("error %s: expected %0d, actual %0d", name, expected, actual);
            $display("TEST FAIL");
            $fatal(1);
        end
    endtask

    task automatic compare_state(input string name);
        int spot;
        spot = first_diff(board_out);
        assert (spot < 0)
        else
        begin
            $display("error %s: cell %0d,%0d expected %0d, actual %0d", name,
                     spot / REF_DIM, spot % REF_DIM,
                     ref_board[spot / REF_DIM][spot % REF_DIM],
                     board_out[spot / REF_DIM][spot % REF_DIM]);
            $display("TEST FAIL");
            $fatal(1);
        end
        expect_equal({name, " turn"}, 32'(ref_turn), 32'(turn));
        expect_equal({name, " black_captures"}, ref_black, 32'(black_captures));
        expect_equal({name, " white_captures"}, ref_white, 32'(white_captures));
    endtask

    // Every wait goes through here so the pulse counts never miss a cycle
    task automatic tick();
        @(negedge clk_in);
        assert (!(move_done && move_rejected))
        else
        begin
            $display("move_done and move_rejected were high in the same cycle");
            $display("TEST FAIL");
            $fatal(1);
        end
        if (move_done)
            done_seen++;
        if (move_rejected)
            rejected_seen++;
    endtask

    task automatic send_strobe(input logic [7:0] move);
        move_strobe = 1'b1;
        move_in     = move;
        strobes++;
        tick();
        move_strobe = 1'b0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    // Mostly the 5x5 corner with one move in eight forced illegal
    function automatic logic [7:0] pick_move();
        int unsigned row;
        int unsigned col;
        int          spot;
        if (lcg_next() % 8 == 0)
        begin
            spot = find_stone(int'(lcg_next() % CELLS));
            if (spot >= 0 && lcg_next() % 2 == 0)
            begin
                row = spot / REF_DIM;
                col = spot % REF_DIM;
            end
            else
            begin
                row = lcg_next() % 16;
                col = lcg_next() % 16;
                if (lcg_next() % 2 == 0)
                    row = REF_DIM + lcg_next() % (16 - REF_DIM);
                else
                    col = REF_DIM + lcg_next() % (16 - REF_DIM);
            end
        end
        else if (lcg_next() % 4 != 0)
        begin
            row = lcg_next() % 5;
            col = lcg_next() % 5;
        end
        else
        begin
            row = lcg_next() % REF_DIM;
            col = lcg_next() % REF_DIM;
        end
        return {row[3:0], col[3:0]};
    endfunction

    task automatic play_legal(input logic [7:0] move, input string name);
        int done_before;
        int rejected_before;
        int waited;
        int taken;
        done_before     = done_seen;
        rejected_before = rejected_seen;
        send_strobe(move);
        expect_equal({name, " busy after accept"}, 1, 32'(busy));
        expect_equal({name, " rejects"}, rejected_before, rejected_seen);
        // Strobe while the update runs
        if (lcg_next() % 4 == 0)
        begin
            send_strobe(pick_move());
            rejected_before++;
            expect_equal("busy strobe rejects", rejected_before, rejected_seen);
        end
        waited = 0;
        while (done_seen == done_before)
        begin
            expect_equal({name, " busy while running"}, 1, 32'(busy));
            tick();
            waited++;
            assert (waited <= MOVE_CYCLES)
            else
            begin
                $display("move_done did not arrive within %0d cycles", MOVE_CYCLES);
                $display("TEST FAIL");
                $fatal(1);
            end
        end
        expect_equal({name, " busy after done"}, 0, 32'(busy));
        expect_equal({name, " rejects"}, rejected_before, rejected_seen);
        taken = play_stone(int'(move[7:4]), int'(move[3:0]));
        if (taken == 1)
            single_caps++;
        else if (taken > 1)
            multi_caps++;
        compare_state(name);
        tick();
        expect_equal({name, " move_done pulses"}, done_before + 1, done_seen);
    endtask

    task automatic play_illegal(input logic [7:0] move, input string name);
        int done_before;
        int rejected_before;
        done_before     = done_seen;
        rejected_before = rejected_seen;
        send_strobe(move);
        expect_equal({name, " move_rejected pulses"}, rejected_before + 1, rejected_seen);
        expect_equal({name, " move_done pulses"}, done_before, done_seen);
        expect_equal({name, " busy"}, 0, 32'(busy));
        compare_state(name);
    endtask

    initial
    begin
        logic [7:0] move;
        rst_in        = 1'b1;
        move_strobe   = 1'b0;
        move_in       = 8'h00;
        done_seen     = 0;
        rejected_seen = 0;
        strobes       = 0;
        single_caps   = 0;
        multi_caps    = 0;
        lcg_seed(32'hd38ddafd);
        clear_position();
        repeat (4) @(negedge clk_in);
        rst_in = 1'b0;
        tick();
        compare_state("reset");
        expect_equal("reset busy", 0, 32'(busy));
        expect_equal("reset move_done", 0, 32'(move_done));
        expect_equal("reset move_rejected", 0, 32'(move_rejected));

        // Black fills in at (0,0) between white stones at (0,1) and (1,0)
        play_legal(8'h88, "suicide setup");
        play_legal(8'h01, "suicide setup");
        play_legal(8'h87, "suicide setup");
        play_legal(8'h10, "suicide setup");
        play_legal(8'h00, "suicide");
        expect_equal("suicide cell", 0, 32'(board_out[0][0]));
        expect_equal("suicide white_captures", 1, 32'(white_captures));
        expect_equal("suicide black_captures", 0, 32'(black_captures));
        expect_equal("suicide turn", 1, 32'(turn));

        while (strobes < STROBE_TARGET)
        begin
            move = pick_move();
            if (is_legal(int'(move[7:4]), int'(move[3:0])))
                play_legal(move, "legal move");
            else
                play_illegal(move, "illegal move");
        end
        $display("%0d strobes, %0d single and %0d multi-stone captures",
                 strobes, single_caps, multi_caps);
        // The random game has to exercise both kinds of capture
        assert (single_caps > 0 && multi_caps > 0)
        else
        begin
            $display("the random game had no single-stone or no multi-stone capture");
            $display("TEST FAIL");
            $fatal(1);
        end
        $display("TEST PASS");
        $finish;
    end

endmodule

// ==== tb/go_ref_model.sv ====
package go_ref_model;

    //////////////////////////////////////////////////////////////////////
    // Model state
    //////////////////////////////////////////////////////////////////////

    localparam int REF_DIM = 9;
    localparam int CELLS   = REF_DIM * REF_DIM;

    localparam logic [1:0] REF_EMPTY = 2'b00;
    localparam logic [1:0] REF_BLACK = 2'b01;
    localparam logic [1:0] REF_WHITE = 2'b10;

    typedef logic [1:0] board_t [REF_DIM-1:0][REF_DIM-1:0];

    board_t      ref_board;
    logic        ref_turn;
    int unsigned ref_black;
    int unsigned ref_white;
    logic [31:0] lcg_state;

    function automatic void lcg_seed(input logic [31:0] seed);
        lcg_state = seed;
    endfunction

    // Upper half of the state, the low bits of an LCG cycle too fast
    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return {16'h0000, lcg_state[31:16]};
    endfunction

    function automatic void clear_position();
        for (int r = 0; r < REF_DIM; r++)
        begin
            for (int c = 0; c < REF_DIM; c++)
                ref_board[r][c] = REF_EMPTY;
        end
        ref_turn  = 1'b0;
        ref_black = 0;
        ref_white = 0;
    endfunction

    function automatic bit is_legal(input int row, input int col);
        if (row >= REF_DIM || col >= REF_DIM)
            return 1'b0;
        return ref_board[row][col] == REF_EMPTY;
    endfunction

    // First occupied cell at or after start, wrapping, or -1
    function automatic int find_stone(input int start);
        int spot;
        for (int i = 0; i < CELLS; i++)
        begin
            spot = (start + i) % CELLS;
            if (ref_board[spot / REF_DIM][spot % REF_DIM] != REF_EMPTY)
                return spot;
        end
        return -1;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Group removal by flood fill
    //////////////////////////////////////////////////////////////////////

    function automatic int remove_dead(input logic [1:0] color);
        bit seen    [REF_DIM-1:0][REF_DIM-1:0];
        int stack_r [CELLS];
        int stack_c [CELLS];
        int group_r [CELLS];
        int group_c [CELLS];
        int sp;
        int gn;
        int r;
        int c;
        int nr;
        int nc;
        bit free;
        int removed;
        removed = 0;
        for (int r0 = 0; r0 < REF_DIM; r0++)
        begin
            for (int c0 = 0; c0 < REF_DIM; c0++)
                seen[r0][c0] = 1'b0;
        end
        for (int r0 = 0; r0 < REF_DIM; r0++)
        begin
            for (int c0 = 0; c0 < REF_DIM; c0++)
            begin
                if (ref_board[r0][c0] == color && !seen[r0][c0])
                begin
                    sp = 1;
                    gn = 0;
                    free = 1'b0;
                    stack_r[0] = r0;
                    stack_c[0] = c0;
                    seen[r0][c0] = 1'b1;
                    while (sp > 0)
                    begin
                        sp--;
                        r = stack_r[sp];
                        c = stack_c[sp];
                        group_r[gn] = r;
                        group_c[gn] = c;
                        gn++;
                        for (int d = 0; d < 4; d++)
                        begin
                            nr = r + ((d == 0) ? -1 : (d == 1) ? 1 : 0);
                            nc = c + ((d == 2) ? -1 : (d == 3) ? 1 : 0);
                            if (nr >= 0 && nr < REF_DIM && nc >= 0 && nc < REF_DIM)
                            begin
                                if (ref_board[nr][nc] == REF_EMPTY)
                                    free = 1'b1;
                                else if (ref_board[nr][nc] == color && !seen[nr][nc])
                                begin
                                    seen[nr][nc] = 1'b1;
                                    stack_r[sp] = nr;
                                    stack_c[sp] = nc;
                                    sp++;
                                end
                            end
                        end
                    end
                    // No liberty anywhere in the group
                    if (!free)
                    begin
                        for (int i = 0; i < gn; i++)
                            ref_board[group_r[i]][group_c[i]] = REF_EMPTY;
                        removed += gn;
                    end
                end
            end
        end
        return removed;
    endfunction

    function automatic int unsigned add_capped(input int unsigned count, input int n);
        return (count + n > 255) ? 255 : count + n;
    endfunction

    // Returns the number of opponent stones taken
    function automatic int play_stone(input int row, input int col);
        logic [1:0] own;
        logic [1:0] opp;
        int         taken;
        int         lost;
        own = ref_turn ? REF_WHITE : REF_BLACK;
        opp = ref_turn ? REF_BLACK : REF_WHITE;
        ref_board[row][col] = own;
        taken = remove_dead(opp);
        lost  = remove_dead(own);
        if (ref_turn)
        begin
            ref_white = add_capped(ref_white, taken);
            ref_black = add_capped(ref_black, lost);
        end
        else
        begin
            ref_black = add_capped(ref_black, taken);
            ref_white = add_capped(ref_white, lost);
        end
        ref_turn = !ref_turn;
        return taken;
    endfunction

    // Index of the first cell that differs from the model, or -1
    function automatic int first_diff(input board_t dut_board);
        for (int r = 0; r < REF_DIM; r++)
        begin
            for (int c = 0; c < REF_DIM; c++)
            begin
                if (dut_board[r][c] !== ref_board[r][c])
                    return r * REF_DIM + c;
            end
        end
        return -1;
    endfunction

endpackage

// ==== design/go_board_top.sv ====
module go_board_top
    import go_pkg::*;
#(
    parameter int BOARD_DIM = 9
)
(
    input  logic              clk_in,
    input  logic              rst_in,
    input  logic              move_strobe,
    input  logic [MOVE_W-1:0] move_in,
    output logic [1:0]        board_out [BOARD_DIM-1:0][BOARD_DIM-1:0],
    output logic              turn,
    output logic              busy,
    output logic              move_done,
    output logic              move_rejected,
    output logic [CAPT_W-1:0] black_captures,
    output logic [CAPT_W-1:0] white_captures
);

    logic [1:0]        next_board [BOARD_DIM-1:0][BOARD_DIM-1:0];
    logic [MOVE_W-1:0] move_reg;
    logic              start_flag;
    logic              board_ready;

    // Position, turn and move checks
    game_keeper #(
        .BOARD_DIM     (BOARD_DIM)
    ) u_game_keeper (
        .clk_in        (clk_in),
        .rst_in        (rst_in),
        .move_strobe   (move_strobe),
        .move_in       (move_in),
        .next_board    (next_board),
        .board_ready   (board_ready),
        .board_bus     (board_out),
        .turn          (turn),
        .move_reg      (move_reg),
        .start_flag    (start_flag),
        .busy          (busy),
        .move_done     (move_done),
        .move_rejected (move_rejected),
        .black_captures(black_captures),
        .white_captures(white_captures)
    );

    // Placement and capture passes
    board_updater #(
        .BOARD_DIM  (BOARD_DIM)
    ) u_board_updater (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .start_flag (start_flag),
        .board_bus  (board_out),
        .turn       (turn),
        .move_in    (move_reg),
        .next_board (next_board),
        .board_ready(board_ready)
    );

endmodule

// ==== design/game_keeper.sv ====
module game_keeper
    import go_pkg::*;
#(
    parameter int BOARD_DIM = 9
)
(
    input  logic              clk_in,
    input  logic              rst_in,
    input  logic              move_strobe,
    input  logic [MOVE_W-1:0] move_in,
    input  logic [1:0]        next_board [BOARD_DIM-1:0][BOARD_DIM-1:0],
    input  logic              board_ready,
    output logic [1:0]        board_bus  [BOARD_DIM-1:0][BOARD_DIM-1:0],
    output logic              turn,
    output logic [MOVE_W-1:0] move_reg,
    output logic              start_flag,
    output logic              busy,
    output logic              move_done,
    output logic              move_rejected,
    output logic [CAPT_W-1:0] black_captures,
    output logic [CAPT_W-1:0] white_captures
);

    localparam int CNT_W = $clog2(BOARD_DIM * BOARD_DIM + 2);

    logic [COORD_W-1:0] row;
    logic [COORD_W-1:0] col;
    logic               in_range;
    logic               target_empty;
    logic               legal;
    logic [CNT_W-1:0]   old_black;
    logic [CNT_W-1:0]   old_white;
    logic [CNT_W-1:0]   new_black;
    logic [CNT_W-1:0]   new_white;
    logic [CNT_W-1:0]   black_gain;
    logic [CNT_W-1:0]   white_gain;
    logic [CAPT_W:0]    black_sum;
    logic [CAPT_W:0]    white_sum;

    //////////////////////////////////////////////////////////////////////
    // Move check
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        row          = move_in[COORD_W +: COORD_W];
        col          = move_in[COORD_W-1:0];
        in_range     = (row < BOARD_DIM) && (col < BOARD_DIM);
        target_empty = 1'b0;
        if (in_range)
            target_empty = (board_bus[row][col] == CELL_EMPTY);
        legal = in_range && target_empty && !busy;
    end

    // Stone census of old and new board
    always_comb
    begin
        old_black = '0;
        old_white = '0;
        new_black = '0;
        new_white = '0;
        for (int r = 0; r < BOARD_DIM; r++)
        begin
            for (int c = 0; c < BOARD_DIM; c++)
            begin
                old_black = old_black + CNT_W'(board_bus[r][c] == CELL_BLACK);
                old_white = old_white + CNT_W'(board_bus[r][c] == CELL_WHITE);
                new_black = new_black + CNT_W'(next_board[r][c] == CELL_BLACK);
                new_white = new_white + CNT_W'(next_board[r][c] == CELL_WHITE);
            end
        end
    end

    // The placed stone counts against the mover, so suicide credits the opponent
    always_comb
    begin
        if (turn)
        begin
            white_gain = old_black - new_black;
            black_gain = old_white + CNT_W'(1) - new_white;
        end
        else
        begin
            black_gain = old_white - new_white;
            white_gain = old_black + CNT_W'(1) - new_black;
        end
        black_sum = {1'b0, black_captures} + (CAPT_W+1)'(black_gain);
        white_sum = {1'b0, white_captures} + (CAPT_W+1)'(white_gain);
    end

    always_ff @(posedge clk_in)
    begin
        if (rst_in)
        begin
            for (int r = 0; r < BOARD_DIM; r++)
            begin
                for (int c = 0; c < BOARD_DIM; c++)
                    board_bus[r][c] <= CELL_EMPTY;
            end
            turn           <= 1'b0;
            start_flag     <= 1'b0;
            busy           <= 1'b0;
            move_done      <= 1'b0;
            move_rejected  <= 1'b0;
            black_captures <= '0;
            white_captures <= '0;
        end
        else
        begin
            start_flag    <= 1'b0;
            move_done     <= 1'b0;
            move_rejected <= 1'b0;
            if (move_strobe)
            begin
                if (legal)
                begin
                    move_reg   <= move_in;
                    start_flag <= 1'b1;
                    busy       <= 1'b1;
                end
                else
                    move_rejected <= 1'b1;
            end
            if (board_ready)
            begin
                board_bus      <= next_board;
                turn           <= ~turn;
                // Saturate at the counter limit
                black_captures <= black_sum[CAPT_W] ? '1 : black_sum[CAPT_W-1:0];
                white_captures <= white_sum[CAPT_W] ? '1 : white_sum[CAPT_W-1:0];
                busy           <= 1'b0;
                move_done      <= 1'b1;
            end
        end
    end

    a_start_idle: assert property (@(posedge clk_in) disable iff (rst_in)
        start_flag |-> $rose(busy));

    a_ready_busy: assert property (@(posedge clk_in) disable iff (rst_in)
        board_ready |-> busy);

endmodule

// ==== design/board_updater.sv ====
module board_updater
    import go_pkg::*;
#(
    parameter int BOARD_DIM = 9
)
(
    input  logic              clk_in,
    input  logic              rst_in,
    input  logic              start_flag,
    input  logic [1:0]        board_bus  [BOARD_DIM-1:0][BOARD_DIM-1:0],
    input  logic              turn,
    input  logic [MOVE_W-1:0] move_in,
    output logic [1:0]        next_board [BOARD_DIM-1:0][BOARD_DIM-1:0],
    output logic              board_ready
);

    //////////////////////////////////////////////////////////////////////
    // One-hot states
    //////////////////////////////////////////////////////////////////////

    localparam logic [7:0] WAITING       = 8'b0000_0001;
    localparam logic [7:0] LOAD_BOARD    = 8'b0000_0010;
    localparam logic [7:0] LOAD_MOVE     = 8'b0000_0100;
    localparam logic [7:0] PULSE_PRUNE_1 = 8'b0000_1000;
    localparam logic [7:0] PRUNE_1       = 8'b0001_0000;
    localparam logic [7:0] PULSE_PRUNE_2 = 8'b0010_0000;
    localparam logic [7:0] PRUNE_2       = 8'b0100_0000;
    localparam logic [7:0] SET_READY     = 8'b1000_0000;

    logic [7:0]         state;
    logic [1:0]         pruned_board [BOARD_DIM-1:0][BOARD_DIM-1:0];
    logic [1:0]         prune_color;
    logic               prune_pulse;
    logic               pruned;
    logic [COORD_W-1:0] row;
    logic [COORD_W-1:0] col;

    assign row = move_in[COORD_W +: COORD_W];
    assign col = move_in[COORD_W-1:0];

    pruner #(
        .BOARD_DIM   (BOARD_DIM)
    ) u_pruner (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .start_flag  (prune_pulse),
        .prune_color (prune_color),
        .board_in    (next_board),
        .pruned_board(pruned_board),
        .done_pulse  (pruned)
    );

    always_ff @(posedge clk_in)
    begin
        if (rst_in)
        begin
            state       <= WAITING;
            board_ready <= 1'b0;
            prune_pulse <= 1'b0;
        end
        else
        begin
            board_ready <= 1'b0;
            prune_pulse <= 1'b0;
            case (state)
                WAITING:
                begin
                    if (start_flag)
                        state <= LOAD_BOARD;
                end
                LOAD_BOARD:
                begin
                    next_board <= board_bus;
                    state      <= LOAD_MOVE;
                end
                LOAD_MOVE:
                begin
                    // Place the mover's stone, opponent is pruned first
                    next_board[row][col] <= {turn, ~turn};
                    prune_color          <= {~turn, turn};
                    state                <= PULSE_PRUNE_1;
                end
                PULSE_PRUNE_1:
                begin
                    prune_pulse <= 1'b1;
                    state       <= PRUNE_1;
                end
                PRUNE_1:
                begin
                    if (pruned)
                    begin
                        prune_color <= {turn, ~turn};
                        state       <= PULSE_PRUNE_2;
                    end
                end
                PULSE_PRUNE_2:
                begin
                    // Feed the first result back in, suicide check next
                    next_board  <= pruned_board;
                    prune_pulse <= 1'b1;
                    state       <= PRUNE_2;
                end
                PRUNE_2:
                begin
                    if (pruned)
                        state <= SET_READY;
                end
                SET_READY:
                begin
                    next_board  <= pruned_board;
                    board_ready <= 1'b1;
                    state       <= WAITING;
                end
                default:
                begin
                    state <= WAITING;
                end
            endcase
        end
    end

    a_no_restart: assert property (@(posedge clk_in) disable iff (rst_in)
        prune_pulse |=> (!prune_pulse throughout pruned [->1]));

endmodule

// ==== design/pruner.sv ====
module pruner
    import go_pkg::*;
#(
    parameter int BOARD_DIM = 9
)
(
    input  logic       clk_in,
    input  logic       rst_in,
    input  logic       start_flag,
    input  logic [1:0] prune_color,
    input  logic [1:0] board_in     [BOARD_DIM-1:0][BOARD_DIM-1:0],
    output logic [1:0] pruned_board [BOARD_DIM-1:0][BOARD_DIM-1:0],
    output logic       done_pulse
);

    localparam int STEP_W = $clog2(BOARD_DIM * BOARD_DIM + 1);

    logic [1:0]        work  [BOARD_DIM-1:0][BOARD_DIM-1:0];
    logic              alive [BOARD_DIM-1:0][BOARD_DIM-1:0];
    logic              seed  [BOARD_DIM-1:0][BOARD_DIM-1:0];
    logic              grown [BOARD_DIM-1:0][BOARD_DIM-1:0];
    logic [1:0]        color_q;
    logic              running;
    logic              grew;
    logic [STEP_W-1:0] step_cnt;

    //////////////////////////////////////////////////////////////////////
    // Liberty propagation, one step over the whole board
    //////////////////////////////////////////////////////////////////////

    // Neighbour indices clamp to the cell itself at the edge; the cell
    // is never empty and its own mark is already counted, so the clamp
    // adds no false liberty
    always_comb
    begin
        grew = 1'b0;
        for (int r = 0; r < BOARD_DIM; r++)
        begin
            for (int c = 0; c < BOARD_DIM; c++)
            begin
                int up;
                int dn;
                int lf;
                int rt;
                up = (r > 0) ? r - 1 : r;
                dn = (r < BOARD_DIM - 1) ? r + 1 : r;
                lf = (c > 0) ? c - 1 : c;
                rt = (c < BOARD_DIM - 1) ? c + 1 : c;

                // Stones touching an empty point are alive from the start
                seed[r][c] = (board_in[r][c] == prune_color) &&
                             ((board_in[up][c] == CELL_EMPTY) ||
                              (board_in[dn][c] == CELL_EMPTY) ||
                              (board_in[r][lf] == CELL_EMPTY) ||
                              (board_in[r][rt] == CELL_EMPTY));

                grown[r][c] = alive[r][c] ||
                              ((work[r][c] == color_q) &&
                               (alive[up][c] || alive[dn][c] ||
                                alive[r][lf] || alive[r][rt]));

                if (grown[r][c] && !alive[r][c])
                    grew = 1'b1;
            end
        end
    end

    // Control
    always_ff @(posedge clk_in)
    begin
        if (rst_in)
        begin
            running    <= 1'b0;
            done_pulse <= 1'b0;
            step_cnt   <= '0;
        end
        else
        begin
            done_pulse <= 1'b0;
            if (!running)
            begin
                if (start_flag)
                begin
                    running  <= 1'b1;
                    step_cnt <= '0;
                end
            end
            else if (grew)
                step_cnt <= step_cnt + 1'b1;
            else
            begin
                running    <= 1'b0;
                done_pulse <= 1'b1;
            end
        end
    end

    // Board copy, marks and result
    always_ff @(posedge clk_in)
    begin
        if (!running && start_flag)
        begin
            work    <= board_in;
            alive   <= seed;
            color_q <= prune_color;
        end
        else if (running)
        begin
            alive <= grown;
            // Nothing new marked, so every unmarked stone is dead
            if (!grew)
            begin
                for (int r = 0; r < BOARD_DIM; r++)
                begin
                    for (int c = 0; c < BOARD_DIM; c++)
                    begin
                        pruned_board[r][c] <= (work[r][c] == color_q && !alive[r][c]) ?
                                              CELL_EMPTY : work[r][c];
                    end
                end
            end
        end
    end

    a_done_single: assert property (@(posedge clk_in) disable iff (rst_in)
        done_pulse |=> !done_pulse);

    a_step_bound: assert property (@(posedge clk_in) disable iff (rst_in)
        step_cnt <= STEP_W'(BOARD_DIM * BOARD_DIM));

endmodule

// ==== design/go_pkg.sv ====
package go_pkg;

    //////////////////////////////////////////////////////////////////////
    // Cell codes
    //////////////////////////////////////////////////////////////////////

    // A stone of colour turn is {turn, ~turn}, so turn 1 means white
    localparam logic [1:0] CELL_EMPTY = 2'b00;
    localparam logic [1:0] CELL_BLACK = 2'b01;
    localparam logic [1:0] CELL_WHITE = 2'b10;

    //////////////////////////////////////////////////////////////////////
    // Move word and counters
    //////////////////////////////////////////////////////////////////////

    // Row in the upper nibble, column in the lower one
    localparam int COORD_W = 4;
    localparam int MOVE_W  = 2 * COORD_W;
    localparam int CAPT_W  = 8;

endpackage
